// ==== common/xif_cfg.svh ====
//////////////////////////////
// build constants for the offload subsystem
// include wherever latency, widths or register offsets are needed
//////////////////////////////

`ifndef XIF_CFG_SVH
`define XIF_CFG_SVH

// execution latency in cycles, handshake to result
`define XIF_LAT 3

// operand and result width
`define XIF_DW 32

// offload id width
`define XIF_IDW 4

// register block word offsets
`define XIF_REG_CTRL     0
`define XIF_REG_ISSUED   1
`define XIF_REG_REJECTED 2

`endif

// ==== common/xif_if.sv ====
//////////////////////////////
// issue, result and control channels between the subsystem blocks
// instantiated once each in the top level
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "xif_cfg.svh"

// offload request with combinational accept response
interface xif_issue_if import xif_pkg::*; ();
  logic                valid;
  logic                ready;
  xop_e                op;
  reg_addr_t           rd;
  logic [`XIF_DW-1:0]  rs1_data;
  logic [`XIF_DW-1:0]  rs2_data;
  logic [`XIF_IDW-1:0] id;
  xmode_e              mode;
  // response, valid while valid is high
  logic                accept;
  logic                writeback;

  modport disp (
    output valid, op, rd, rs1_data, rs2_data, id, mode,
    input  ready, accept, writeback
  );

  modport copro (
    input  valid, op, rd, rs1_data, rs2_data, id, mode,
    output ready, accept, writeback
  );
endinterface : xif_issue_if

// result return, always accepted
interface xif_result_if import xif_pkg::*; ();
  logic                valid;
  reg_addr_t           rd;
  logic [`XIF_DW-1:0]  data;
  logic [`XIF_IDW-1:0] id;

  modport copro (output valid, rd, data, id);
  modport disp  (input  valid, rd, data, id);
endinterface : xif_result_if

// register block settings and event pulses
interface xif_ctrl_if import xif_pkg::*; ();
  logic      enable;
  priv_lvl_e priv;
  // one cycle per event
  logic      issued_pulse;
  logic      rejected_pulse;

  modport csr  (output enable, priv, input issued_pulse, rejected_pulse);
  modport disp (input enable, priv, output issued_pulse, rejected_pulse);
endinterface : xif_ctrl_if

`default_nettype wire

// ==== common/xif_pkg.sv ====
//////////////////////////////
// shared types of the offload subsystem
// imported by wildcard into dispatcher, coprocessor and interfaces
//////////////////////////////

`default_nettype none

package xif_pkg;

  //////////////////////////////
  // coprocessor opcodes
  //////////////////////////////

  // encodings 5..7 are illegal and rejected by the coprocessor
  typedef enum logic [2:0] {
    XOP_ADD = 3'd0,
    XOP_SUB = 3'd1,
    XOP_XOR = 3'd2,
    XOP_ACC = 3'd3,
    XOP_CLR = 3'd4
  } xop_e;

  //////////////////////////////
  // privilege and issue mode
  //////////////////////////////

  // privilege level as held in the ctrl register
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_H = 2'd2,
    PRIV_M = 2'd3
  } priv_lvl_e;

  // mode field sent with every offload
  typedef enum logic [1:0] {
    MODE_U = 2'd0,
    MODE_S = 2'd1,
    MODE_H = 2'd2,
    MODE_M = 2'd3
  } xmode_e;

  // integer register address
  typedef logic [4:0] reg_addr_t;

endpackage : xif_pkg

`default_nettype wire

// ==== dv/xif_assert.sv ====
//////////////////////////////
// dispatcher protocol assertions, bound into every x_disp
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "xif_cfg.svh"

module xif_assert
  import xif_pkg::*;
(
  input wire logic        clk_i,
  input wire logic        rst_ni,
  input wire logic        hs_i,
  input wire logic        accept_i,
  input wire logic        wb_i,
  input wire logic        illegal_i,
  input wire logic [2:0]  op_i,
  input wire logic [1:0]  priv_i,
  input wire reg_addr_t   rd_i,
  input wire logic [31:0] sb_i,
  input wire logic        res_valid_i,
  input wire reg_addr_t   res_rd_i
);

  logic busy_set;
  logic bad_op;

  // accepted offload that will write a tracked register
  assign busy_set = hs_i && accept_i && wb_i && (rd_i != '0);
  // undefined encoding, or clr outside machine mode
  assign bad_op   = (op_i > 3'd4) || ((op_i == XOP_CLR) && (priv_i != PRIV_M));

  // destination stays busy for XIF_LAT cycles after its handshake
  for (genvar k = 1; k <= `XIF_LAT; k++) begin : g_busy
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     hs_i |-> !($past(busy_set, k) && ($past(rd_i, k) == rd_i)))
      else $error("offload issued while its destination register is busy");
  end

  // x0 is never tracked
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (res_valid_i && (res_rd_i != '0)) |-> sb_i[res_rd_i])
    else $error("result returned for a register that is not busy");

  // rejection only in a handshake cycle, and only for a bad op
  assert property (@(posedge clk_i) disable iff (!rst_ni) illegal_i |-> (hs_i && bad_op))
    else $error("illegal pulse outside a handshake cycle or for a legal op");

endmodule : xif_assert

bind x_disp xif_assert u_assert (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .hs_i        (hs),
  .accept_i    (issue.accept),
  .wb_i        (issue.writeback),
  .illegal_i   (illegal_o),
  .op_i        (instr_op_i),
  .priv_i      (ctrl.priv),
  .rd_i        (instr_rd_i),
  .sb_i        (sb_q),
  .res_valid_i (result.valid),
  .res_rd_i    (result.rd)
);

`default_nettype wire

// ==== dv/xif_tb.sv ====
//////////////////////////////
// directed testbench for the offload subsystem
// drives instructions and wishbone accesses, checks against a model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "xif_cfg.svh"

module xif_tb
  import xif_pkg::*;
();

  localparam int DW = `XIF_DW;
  // tests need a few hundred cycles
  localparam int MAX_CYCLES = 2000;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 instr_valid_i;
  logic [2:0]           instr_op_i;
  reg_addr_t            instr_rd_i;
  reg_addr_t            instr_rs1_i;
  reg_addr_t            instr_rs2_i;
  logic [DW-1:0]        rs1_data_i;
  logic [DW-1:0]        rs2_data_i;
  logic                 instr_ready_o;
  logic                 illegal_o;
  logic                 wb_cyc_i;
  logic                 wb_stb_i;
  logic                 wb_we_i;
  logic [1:0]           wb_adr_i;
  logic [DW-1:0]        wb_dat_i;
  logic [DW-1:0]        wb_dat_o;
  logic                 wb_ack_o;
  logic                 result_valid_o;
  reg_addr_t            result_rd_o;
  logic [DW-1:0]        result_data_o;
  logic [`XIF_IDW-1:0]  result_id_o;

  // expected result, due is the cycle count in which it must show
  typedef struct packed {
    reg_addr_t           rd;
    logic [DW-1:0]       data;
    logic [`XIF_IDW-1:0] id;
    int                  due;
  } exp_res_t;

  //////////////////////////////
  // reference model state
  //////////////////////////////

  int                  cycle_cnt;
  int                  seed;
  bit                  en_m;
  priv_lvl_e           priv_m;
  logic [DW-1:0]       acc_m;
  logic [`XIF_IDW-1:0] next_id;
  int                  issued_m;
  int                  rejected_m;
  // last cycle in which a register is still busy
  int                  busy_until [32];
  exp_res_t            exp_q [$];

  xif_subsys_top uut (.*);

  always #20 clk_i = ~clk_i;

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [DW-1:0] got,
                            input logic [DW-1:0] exp);
    if (got !== exp)
      report_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_rd(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp)
      report_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_id(input string name, input logic [`XIF_IDW-1:0] got,
                          input logic [`XIF_IDW-1:0] exp);
    if (got !== exp)
      report_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    if (got !== exp)
      report_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // cycle count and run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
      report_failure("timeout, the tests did not finish within the cycle limit");
  end

  // result monitor, outputs are registered so the falling edge is stable
  always @(negedge clk_i) begin
    exp_res_t e;
    if (rst_ni) begin
      if (result_valid_o) begin
        if (exp_q.size() == 0)
          report_failure("a result came back with no offload outstanding");
        e = exp_q.pop_front();
        if (e.due != cycle_cnt)
          report_failure($sformatf("result for id %0d came in cycle %0d, due in cycle %0d",
                                   e.id, cycle_cnt, e.due));
        check_rd("result_rd_o", result_rd_o, e.rd);
        check_data("result_data_o", result_data_o, e.data);
        check_id("result_id_o", result_id_o, e.id);
      end else if (exp_q.size() != 0 && exp_q[0].due <= cycle_cnt) begin
        report_failure("an expected result did not arrive on time");
      end
    end
  end

  //////////////////////////////
  // model helpers
  //////////////////////////////

  function automatic bit reg_busy(input reg_addr_t r);
    return (r != '0) && (cycle_cnt <= busy_until[r]);
  endfunction

  function automatic bit ready_expected(input reg_addr_t rd, input reg_addr_t rs1,
                                        input reg_addr_t rs2);
    return en_m && !reg_busy(rd) && !reg_busy(rs1) && !reg_busy(rs2);
  endfunction

  //////////////////////////////
  // bus tasks
  //////////////////////////////

  // starts and ends just after a falling edge
  task automatic send_instr(input logic [2:0] op, input reg_addr_t rd, input reg_addr_t rs1,
                            input reg_addr_t rs2, input logic [DW-1:0] d1,
                            input logic [DW-1:0] d2);
    bit            exp_ill;
    logic [DW-1:0] res;
    instr_valid_i = 1'b1;
    instr_op_i    = op;
    instr_rd_i    = rd;
    instr_rs1_i   = rs1;
    instr_rs2_i   = rs2;
    rs1_data_i    = d1;
    rs2_data_i    = d2;
    #1;
    check_flag("instr_ready_o", instr_ready_o, ready_expected(rd, rs1, rs2));
    while (!instr_ready_o) begin
      @(negedge clk_i);
      #1;
      check_flag("instr_ready_o", instr_ready_o, ready_expected(rd, rs1, rs2));
    end
    // handshake on the coming rising edge
    exp_ill = (op > 3'd4) || (op == XOP_CLR && priv_m != PRIV_M);
    check_flag("illegal_o", illegal_o, exp_ill);
    if (exp_ill) begin
      rejected_m++;
    end else begin
      issued_m++;
      case (op)
        XOP_SUB: res = d1 - d2;
        XOP_XOR: res = d1 ^ d2;
        XOP_ACC: res = acc_m + d1;
        XOP_CLR: res = '0;
        default: res = d1 + d2;
      endcase
      if (op == XOP_ACC)
        acc_m = res;
      if (op == XOP_CLR)
        acc_m = '0;
      // clr has no writeback
      if (op != XOP_CLR) begin
        exp_q.push_back('{rd: rd, data: res, id: next_id, due: cycle_cnt + `XIF_LAT});
        if (rd != '0)
          busy_until[rd] = cycle_cnt + `XIF_LAT;
      end
    end
    next_id = next_id + 1'b1;
    @(negedge clk_i);
    instr_valid_i = 1'b0;
  endtask

  // ack one cycle after the strobe, then one idle cycle
  task automatic wb_access(input bit we, input logic [1:0] adr, input logic [DW-1:0] wdata,
                           output logic [DW-1:0] rdata);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    #1;
    check_flag("wb_ack_o", wb_ack_o, 1'b0);
    @(negedge clk_i);
    check_flag("wb_ack_o", wb_ack_o, 1'b1);
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic write_ctrl(input bit en, input priv_lvl_e priv);
    logic [DW-1:0] rdata;
    wb_access(1'b1, 2'(`XIF_REG_CTRL), DW'({priv, en}), rdata);
    en_m   = en;
    priv_m = priv;
  endtask

  task automatic read_check(input logic [1:0] adr, input logic [DW-1:0] exp);
    logic [DW-1:0] got;
    wb_access(1'b0, adr, '0, got);
    check_data("wb_dat_o", got, exp);
  endtask

  task automatic drain_results();
    while (exp_q.size() != 0)
      @(negedge clk_i);
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic enable_after_reset();
    check_flag("result_valid_o", result_valid_o, 1'b0);
    check_flag("illegal_o", illegal_o, 1'b0);
    check_flag("wb_ack_o", wb_ack_o, 1'b0);
    repeat (3) begin
      check_flag("instr_ready_o", instr_ready_o, 1'b0);
      @(negedge clk_i);
    end
    write_ctrl(1'b1, PRIV_M);
    read_check(2'(`XIF_REG_CTRL), DW'(7));
    check_flag("instr_ready_o", instr_ready_o, 1'b1);
  endtask

  // each source is the previous destination, so some stalls
  task automatic alu_ops_random();
    for (int i = 0; i < 6; i++)
      send_instr(3'(i % 3), reg_addr_t'(i + 1), reg_addr_t'(i), 5'd0,
                 $random(seed), $random(seed));
    drain_results();
  endtask

  task automatic issue_back_to_back();
    send_instr(XOP_ADD, 5'd10, 5'd20, 5'd21, $random(seed), $random(seed));
    send_instr(XOP_SUB, 5'd11, 5'd20, 5'd21, $random(seed), $random(seed));
    send_instr(XOP_XOR, 5'd12, 5'd20, 5'd21, $random(seed), $random(seed));
    drain_results();
  endtask

  task automatic stall_on_dependency();
    send_instr(XOP_ADD, 5'd5, 5'd0, 5'd0, $random(seed), $random(seed));
    // rs1 waits for x5
    send_instr(XOP_SUB, 5'd6, 5'd5, 5'd0, $random(seed), $random(seed));
    // rd waits for x6
    send_instr(XOP_XOR, 5'd6, 5'd0, 5'd0, $random(seed), $random(seed));
    drain_results();
  endtask

  task automatic reject_cases();
    logic [DW-1:0] d;
    for (int op = 5; op < 8; op++)
      send_instr(3'(op), 5'd7, 5'd0, 5'd0, $random(seed), $random(seed));
    write_ctrl(1'b1, PRIV_U);
    send_instr(XOP_CLR, 5'd0, 5'd0, 5'd0, '0, '0);
    send_instr(XOP_ACC, 5'd8, 5'd0, 5'd0, $random(seed), '0);
    write_ctrl(1'b1, PRIV_M);
    send_instr(XOP_CLR, 5'd0, 5'd0, 5'd0, '0, '0);
    // accumulator starts over
    d = $random(seed);
    send_instr(XOP_ACC, 5'd9, 5'd0, 5'd0, d, '0);
    drain_results();
  endtask

  task automatic wait_while_disabled();
    write_ctrl(1'b0, PRIV_M);
    instr_valid_i = 1'b1;
    instr_op_i    = XOP_ADD;
    instr_rd_i    = 5'd3;
    repeat (4) begin
      #1;
      check_flag("instr_ready_o", instr_ready_o, 1'b0);
      check_flag("illegal_o", illegal_o, 1'b0);
      @(negedge clk_i);
    end
    instr_valid_i = 1'b0;
    write_ctrl(1'b1, PRIV_M);
    send_instr(XOP_ADD, 5'd3, 5'd1, 5'd2, $random(seed), $random(seed));
    drain_results();
  endtask

  task automatic counter_readback();
    read_check(2'(`XIF_REG_ISSUED), DW'(issued_m));
    read_check(2'(`XIF_REG_REJECTED), DW'(rejected_m));
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    seed          = 36565;
    cycle_cnt     = 0;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_op_i    = '0;
    instr_rd_i    = '0;
    instr_rs1_i   = '0;
    instr_rs2_i   = '0;
    rs1_data_i    = '0;
    rs2_data_i    = '0;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    wb_we_i       = 1'b0;
    wb_adr_i      = '0;
    wb_dat_i      = '0;
    en_m          = 1'b0;
    priv_m        = PRIV_M;
    acc_m         = '0;
    next_id       = '0;
    issued_m      = 0;
    rejected_m    = 0;
    foreach (busy_until[i])
      busy_until[i] = 0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    enable_after_reset();
    alu_ops_random();
    issue_back_to_back();
    stall_on_dependency();
    reject_cases();
    wait_while_disabled();
    counter_readback();
    @(negedge clk_i);
    $display("Test completed successfully");
    $finish;
  end

endmodule : xif_tb

`default_nettype wire

// ==== hdl/x_copro.sv ====
//////////////////////////////
// fixed latency coprocessor with add, sub, xor and accumulator
// result leaves XIF_LAT cycles after the issue handshake
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "xif_cfg.svh"

module x_copro
  import xif_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  xif_issue_if.copro  issue,
  xif_result_if.copro result
);

  logic                accept;
  logic                fire;
  logic [`XIF_DW-1:0]  acc_q;
  logic [`XIF_DW-1:0]  acc_sum;
  logic [`XIF_DW-1:0]  alu_res;

  // result pipeline, stage 0 holds the computed value
  logic [`XIF_LAT-1:0] v_q;
  reg_addr_t           rd_q   [`XIF_LAT];
  logic [`XIF_IDW-1:0] id_q   [`XIF_LAT];
  logic [`XIF_DW-1:0]  data_q [`XIF_LAT];

  //////////////////////////////
  // decode and accept
  //////////////////////////////

  // clr is privileged, illegal encodings fall to default
  always_comb begin
    case (issue.op)
      XOP_ADD, XOP_SUB, XOP_XOR, XOP_ACC: accept = 1'b1;
      XOP_CLR:                            accept = (issue.mode == MODE_M);
      default:                            accept = 1'b0;
    endcase
  end

  // one op per cycle
  assign issue.ready     = 1'b1;
  assign issue.accept    = accept;
  assign issue.writeback = accept & (issue.op != XOP_CLR);

  assign fire = issue.valid & issue.ready & accept;

  //////////////////////////////
  // execute
  //////////////////////////////

  assign acc_sum = acc_q + issue.rs1_data;

  always_comb begin
    case (issue.op)
      XOP_SUB: alu_res = issue.rs1_data - issue.rs2_data;
      XOP_XOR: alu_res = issue.rs1_data ^ issue.rs2_data;
      // acc returns the new sum
      XOP_ACC: alu_res = acc_sum;
      default: alu_res = issue.rs1_data + issue.rs2_data;
    endcase
  end

  // accumulator
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (fire & (issue.op == XOP_ACC)) begin
      acc_q <= acc_sum;
    end else if (fire & (issue.op == XOP_CLR)) begin
      acc_q <= '0;
    end
  end

  //////////////////////////////
  // latency pipeline
  //////////////////////////////

  // valid bits, only writeback ops enter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      v_q <= '0;
    end else begin
      v_q[0] <= fire & issue.writeback;
      for (int i = 1; i < `XIF_LAT; i++) begin
        v_q[i] <= v_q[i-1];
      end
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    rd_q[0]   <= issue.rd;
    id_q[0]   <= issue.id;
    data_q[0] <= alu_res;
    for (int i = 1; i < `XIF_LAT; i++) begin
      rd_q[i]   <= rd_q[i-1];
      id_q[i]   <= id_q[i-1];
      data_q[i] <= data_q[i-1];
    end
  end

  // last stage drives the result channel
  assign result.valid = v_q[`XIF_LAT-1];
  assign result.rd    = rd_q[`XIF_LAT-1];
  assign result.id    = id_q[`XIF_LAT-1];
  assign result.data  = data_q[`XIF_LAT-1];

endmodule : x_copro

`default_nettype wire

// ==== hdl/xif_subsys_top.sv ====
//////////////////////////////
// offload subsystem top level
// dispatcher, register block and coprocessor on plain ports
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "xif_cfg.svh"

module xif_subsys_top (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,

  // instruction stream
  input  wire logic                instr_valid_i,
  input  wire logic [2:0]          instr_op_i,
  input  wire logic [4:0]          instr_rd_i,
  input  wire logic [4:0]          instr_rs1_i,
  input  wire logic [4:0]          instr_rs2_i,
  input  wire logic [`XIF_DW-1:0]  rs1_data_i,
  input  wire logic [`XIF_DW-1:0]  rs2_data_i,
  output logic                     instr_ready_o,
  output logic                     illegal_o,

  // wishbone classic slave
  input  wire logic                wb_cyc_i,
  input  wire logic                wb_stb_i,
  input  wire logic                wb_we_i,
  input  wire logic [1:0]          wb_adr_i,
  input  wire logic [`XIF_DW-1:0]  wb_dat_i,
  output logic [`XIF_DW-1:0]       wb_dat_o,
  output logic                     wb_ack_o,

  // results
  output logic                     result_valid_o,
  output logic [4:0]               result_rd_o,
  output logic [`XIF_DW-1:0]       result_data_o,
  output logic [`XIF_IDW-1:0]      result_id_o
);

  xif_issue_if  issue_if  ();
  xif_result_if result_if ();
  xif_ctrl_if   ctrl_if   ();

  x_disp u_disp (
    .clk_i, .rst_ni,
    .instr_valid_i, .instr_op_i, .instr_rd_i, .instr_rs1_i, .instr_rs2_i,
    .rs1_data_i, .rs2_data_i, .instr_ready_o, .illegal_o,
    .issue  (issue_if.disp),
    .result (result_if.disp),
    .ctrl   (ctrl_if.disp)
  );

  x_disp_csr u_csr (
    .clk_i, .rst_ni,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .ctrl (ctrl_if.csr)
  );

  x_copro u_copro (
    .clk_i, .rst_ni,
    .issue  (issue_if.copro),
    .result (result_if.copro)
  );

  // result channel out to the pins
  assign result_valid_o = result_if.valid;
  assign result_rd_o    = result_if.rd;
  assign result_data_o  = result_if.data;
  assign result_id_o    = result_if.id;

endmodule : xif_subsys_top

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module xif_tb \
  -f xif_subsys.f -o xif_sim > build.log 2>&1 \
  && ./obj_dir/xif_sim > sim.log 2>&1 \
  || echo "build or simulation stopped with an error"
grep -q "Test completed successfully" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== x_disp/x_disp.sv ====
//////////////////////////////
// dispatcher from the instruction stream to the coprocessor
// scoreboard stall, id tagging and rejection to illegal pulse
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "xif_cfg.svh"

module x_disp
  import xif_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               rst_ni,

  // instruction stream
  input  wire logic               instr_valid_i,
  input  wire logic [2:0]         instr_op_i,
  input  wire reg_addr_t          instr_rd_i,
  input  wire reg_addr_t          instr_rs1_i,
  input  wire reg_addr_t          instr_rs2_i,
  input  wire logic [`XIF_DW-1:0] rs1_data_i,
  input  wire logic [`XIF_DW-1:0] rs2_data_i,
  output logic                    instr_ready_o,
  output logic                    illegal_o,

  // coprocessor and register block
  xif_issue_if.disp               issue,
  xif_result_if.disp              result,
  xif_ctrl_if.disp                ctrl
);

  logic [31:0]         sb_q, sb_d;
  logic [`XIF_IDW-1:0] id_q;
  logic                dep;
  logic                hs;

  //////////////////////////////
  // stall
  //////////////////////////////

  // registered scoreboard only, a result frees its rd one cycle later
  // x0 is never set, so no special case here
  assign dep = sb_q[instr_rs1_i] | sb_q[instr_rs2_i] | sb_q[instr_rd_i];

  assign instr_ready_o = ctrl.enable & ~dep & issue.ready;

  //////////////////////////////
  // issue request
  //////////////////////////////

  // valid only depends on enable and scoreboard
  // both only relax while waiting for ready, so the request stays up
  assign issue.valid    = instr_valid_i & ctrl.enable & ~dep;
  // raw encoding passes through, copro rejects 5..7
  assign issue.op       = xop_e'(instr_op_i);
  assign issue.rd       = instr_rd_i;
  assign issue.rs1_data = rs1_data_i;
  assign issue.rs2_data = rs2_data_i;
  assign issue.id       = id_q;

  // same cycle as the instruction handshake
  assign hs = issue.valid & issue.ready;

  // privilege level to issue mode
  always_comb begin
    case (ctrl.priv)
      PRIV_U:  issue.mode = MODE_U;
      PRIV_S:  issue.mode = MODE_S;
      PRIV_H:  issue.mode = MODE_H;
      default: issue.mode = MODE_M;
    endcase
  end

  //////////////////////////////
  // response handling
  //////////////////////////////

  // rejected offload is consumed, no result, no busy bit
  assign illegal_o           = hs & ~issue.accept;
  assign ctrl.issued_pulse   = hs & issue.accept;
  assign ctrl.rejected_pulse = illegal_o;

  //////////////////////////////
  // scoreboard and id
  //////////////////////////////

  always_comb begin
    sb_d = sb_q;
    // result frees its destination
    if (result.valid) begin
      sb_d[result.rd] = 1'b0;
    end
    // new writeback marks rd busy until its result
    if (hs & issue.accept & issue.writeback & (instr_rd_i != '0)) begin
      sb_d[instr_rd_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sb_q <= '0;
      id_q <= '0;
    end else begin
      sb_q <= sb_d;
      // every handshake takes an id, rejected ones too
      if (hs) begin
        id_q <= id_q + 1'b1;
      end
    end
  end

endmodule : x_disp

`default_nettype wire

// ==== x_disp/x_disp_csr.sv ====
//////////////////////////////
// wishbone classic register block
// offload enable, privilege and offload counters
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "xif_cfg.svh"

module x_disp_csr
  import xif_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               rst_ni,

  // wishbone classic slave, word addressed
  input  wire logic               wb_cyc_i,
  input  wire logic               wb_stb_i,
  input  wire logic               wb_we_i,
  input  wire logic [1:0]         wb_adr_i,
  input  wire logic [`XIF_DW-1:0] wb_dat_i,
  output logic [`XIF_DW-1:0]      wb_dat_o,
  output logic                    wb_ack_o,

  xif_ctrl_if.csr                 ctrl
);

  logic               enable_q;
  priv_lvl_e          priv_q;
  logic [`XIF_DW-1:0] issued_q;
  logic [`XIF_DW-1:0] rejected_q;
  logic [`XIF_DW-1:0] rdata;
  logic               access;

  // ack low in the cycle after an ack, so back to back strobes get a gap
  assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  // read mux
  always_comb begin
    case (wb_adr_i)
      `XIF_REG_CTRL:     rdata = {{(`XIF_DW-3){1'b0}}, priv_q, enable_q};
      `XIF_REG_ISSUED:   rdata = issued_q;
      `XIF_REG_REJECTED: rdata = rejected_q;
      default:           rdata = '0;
    endcase
  end

  //////////////////////////////
  // control state and counters
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o   <= 1'b0;
      enable_q   <= 1'b0;
      priv_q     <= PRIV_M;
      issued_q   <= '0;
      rejected_q <= '0;
    end else begin
      wb_ack_o <= access;
      // only ctrl is writable
      if (access & wb_we_i & (wb_adr_i == `XIF_REG_CTRL)) begin
        enable_q <= wb_dat_i[0];
        priv_q   <= priv_lvl_e'(wb_dat_i[2:1]);
      end
      if (ctrl.issued_pulse) begin
        issued_q <= issued_q + 1'b1;
      end
      if (ctrl.rejected_pulse) begin
        rejected_q <= rejected_q + 1'b1;
      end
    end
  end

  // read data captured with the ack
  always_ff @(posedge clk_i) begin
    if (access) begin
      wb_dat_o <= rdata;
    end
  end

  assign ctrl.enable = enable_q;
  assign ctrl.priv   = priv_q;

endmodule : x_disp_csr

`default_nettype wire

// ==== xif_subsys.f ====
+incdir+common
common/xif_pkg.sv
common/xif_if.sv
x_disp/x_disp.sv
x_disp/x_disp_csr.sv
hdl/x_copro.sv
hdl/xif_subsys_top.sv
dv/xif_assert.sv
dv/xif_tb.sv
